// ==== Makefile ====
# Verilator build and run for the decoupled RV32I core

VERILATOR ?= verilator
TOP       ?= tb_rv32_core
SEED      ?= 1
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
hw/rv32_isa_pkg.sv
hw/rv32_pipe_pkg.sv
hw/decoded_op_if.sv
hw/rv32_decoder.sv
hw/op_queue.sv
hw/rv32_execute.sv
hw/rv32_core_top.sv
verif/tb_rv32_core.sv

// ==== hw/decoded_op_if.sv ====
// Decoded operation link between core stages
// Valid/ready transfer of one operation per cycle
`timescale 1ns/1ps

interface decoded_op_if import rv32_isa_pkg::*, rv32_pipe_pkg::*;;

	logic      valid;
	logic      ready;
	op_class_e cls;
	alu_op_e   alu;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	reg_idx_t  rd;
	logic      use_imm; // Second operand is imm
	xlen_t     imm;
	xlen_t     pc;
	xlen_t     target;  // pc + imm

	modport src (output valid, cls, alu, rs1, rs2, rd, use_imm, imm, pc, target,
		input ready);

	modport snk (input valid, cls, alu, rs1, rs2, rd, use_imm, imm, pc, target,
		output ready);

endinterface

// ==== hw/op_queue.sv ====
// Decoded operation FIFO between decoder and execution unit
// Circular buffer, one push and one pop per cycle
`timescale 1ns/1ps

module op_queue import rv32_isa_pkg::*, rv32_pipe_pkg::*; #(
	parameter int QUEUE_DEPTH = 4 // Power of two, 2 or more
) (
	input logic clk,
	input logic rst_n,
	decoded_op_if.snk in_op,
	decoded_op_if.src out_op
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

	op_class_e cls_q     [QUEUE_DEPTH];
	alu_op_e   alu_q     [QUEUE_DEPTH];
	reg_idx_t  rs1_q     [QUEUE_DEPTH];
	reg_idx_t  rs2_q     [QUEUE_DEPTH];
	reg_idx_t  rd_q      [QUEUE_DEPTH];
	logic      use_imm_q [QUEUE_DEPTH];
	xlen_t     imm_q     [QUEUE_DEPTH];
	xlen_t     pc_q      [QUEUE_DEPTH];
	xlen_t     target_q  [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr, rd_ptr; // Wrap at depth
	logic [PTR_W:0]   cnt;
	logic             push, pop;

	assign in_op.ready  = (cnt != FULL_CNT);
	assign out_op.valid = (cnt != '0);
	assign push = in_op.valid && in_op.ready;
	assign pop  = out_op.valid && out_op.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				cnt <= cnt + 1'b1;
			else if (pop && !push)
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			cls_q[wr_ptr]     <= in_op.cls;
			alu_q[wr_ptr]     <= in_op.alu;
			rs1_q[wr_ptr]     <= in_op.rs1;
			rs2_q[wr_ptr]     <= in_op.rs2;
			rd_q[wr_ptr]      <= in_op.rd;
			use_imm_q[wr_ptr] <= in_op.use_imm;
			imm_q[wr_ptr]     <= in_op.imm;
			pc_q[wr_ptr]      <= in_op.pc;
			target_q[wr_ptr]  <= in_op.target;
		end
	end

	assign out_op.cls     = cls_q[rd_ptr];
	assign out_op.alu     = alu_q[rd_ptr];
	assign out_op.rs1     = rs1_q[rd_ptr];
	assign out_op.rs2     = rs2_q[rd_ptr];
	assign out_op.rd      = rd_q[rd_ptr];
	assign out_op.use_imm = use_imm_q[rd_ptr];
	assign out_op.imm     = imm_q[rd_ptr];
	assign out_op.pc      = pc_q[rd_ptr];
	assign out_op.target  = target_q[rd_ptr];

	// Stalled producer keeps its operation
	a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		in_op.valid && !in_op.ready |=> in_op.valid &&
		$stable({in_op.cls, in_op.alu, in_op.rs1, in_op.rs2, in_op.rd,
			in_op.use_imm, in_op.imm, in_op.pc, in_op.target}));

endmodule

// ==== hw/rv32_core_top.sv ====
// Decoupled RV32I core
// Decoder, operation queue and execution unit behind four-phase ports
`timescale 1ns/1ps

module rv32_core_top import rv32_isa_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     insn_req,
	output logic     insn_ack,
	input  insn_t    insn,
	input  xlen_t    pc,
	output logic     retire_req,
	input  logic     retire_ack,
	output xlen_t    retire_pc,
	output reg_idx_t retire_rd,
	output xlen_t    retire_wdata,
	output xlen_t    retire_pc_next,
	output logic     retire_trap
);

	decoded_op_if dec_if (); // Decoder to queue
	decoded_op_if exe_if (); // Queue to execution unit

	rv32_decoder u_decoder (
		.clk      (clk),
		.rst_n    (rst_n),
		.insn_req (insn_req),
		.insn     (insn),
		.pc       (pc),
		.insn_ack (insn_ack),
		.dec      (dec_if.src)
	);

	op_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk    (clk),
		.rst_n  (rst_n),
		.in_op  (dec_if.snk),
		.out_op (exe_if.src)
	);

	rv32_execute u_execute (
		.clk            (clk),
		.rst_n          (rst_n),
		.op             (exe_if.snk),
		.retire_req     (retire_req),
		.retire_ack     (retire_ack),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_wdata   (retire_wdata),
		.retire_pc_next (retire_pc_next),
		.retire_trap    (retire_trap)
	);

endmodule

// ==== hw/rv32_decoder.sv ====
// RV32I decoder stage
// Four-phase instruction intake, classification and immediate build
`timescale 1ns/1ps

module rv32_decoder import rv32_isa_pkg::*, rv32_pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  insn_req,
	input  insn_t insn,
	input  xlen_t pc,
	output logic  insn_ack,
	decoded_op_if.src dec
);

	hs_state_e state;
	logic      slot_free;
	logic      capture;
	opcode_e   opcode;
	funct3_t   f3;
	funct7_t   f7;
	op_class_e cls_d;
	alu_op_e   alu_d;
	xlen_t     imm_d;
	reg_idx_t  rd_d;
	logic      use_imm_d;
	logic      plain_ok;
	logic      alu_legal;
	xlen_t     imm_i, imm_u, imm_j, imm_b;

	assign opcode = opcode_e'(insn[6:0]);
	assign f3     = insn[14:12];
	assign f7     = insn[31:25];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

	always_comb begin
		cls_d     = cls_illegal; // Anything unmatched traps
		alu_d     = alu_add;
		imm_d     = imm_i;
		rd_d      = insn[11:7];
		use_imm_d = 1'b0;
		plain_ok  = 1'b0;
		alu_legal = 1'b0;
		case (opcode)
			op_lui: begin
				cls_d = cls_lui;
				imm_d = imm_u;
			end
			op_auipc: begin
				cls_d = cls_auipc;
				imm_d = imm_u;
			end
			op_jal: begin
				cls_d = cls_jal;
				imm_d = imm_j;
			end
			op_jalr: begin
				if (f3 == F3_JALR)
					cls_d = cls_jalr;
			end
			op_branch: begin
				cls_d = cls_branch;
				imm_d = imm_b;
				rd_d  = '0; // Branches never write
				case (f3)
					F3_BEQ:  alu_d = alu_beq;
					F3_BNE:  alu_d = alu_bne;
					F3_BLT:  alu_d = alu_blt;
					F3_BGE:  alu_d = alu_bge;
					F3_BLTU: alu_d = alu_bltu;
					F3_BGEU: alu_d = alu_bgeu;
					default: cls_d = cls_illegal; // 010 and 011
				endcase
			end
			op_imm, op_reg: begin
				use_imm_d = (opcode == op_imm);
				plain_ok  = use_imm_d || (f7 == F7_BASE);
				alu_legal = plain_ok;
				case (f3)
					F3_ADD_SUB: begin
						if (!use_imm_d && f7 == F7_ALT) begin
							alu_d     = alu_sub;
							alu_legal = 1'b1;
						end
					end
					F3_SLL: begin
						alu_d     = alu_sll;
						alu_legal = (f7 == F7_BASE); // Also checks SLLI upper bits
					end
					F3_SR: begin
						alu_d     = (f7 == F7_ALT) ? alu_sra : alu_srl;
						alu_legal = (f7 == F7_BASE) || (f7 == F7_ALT);
					end
					F3_SLT:  alu_d = alu_slt;
					F3_SLTU: alu_d = alu_sltu;
					F3_XOR:  alu_d = alu_xor;
					F3_OR:   alu_d = alu_or;
					default: alu_d = alu_and;
				endcase
				if (alu_legal)
					cls_d = cls_alu;
			end
			default: cls_d = cls_illegal;
		endcase
	end

	assign slot_free = !dec.valid || dec.ready;
	assign capture   = (state == hs_idle) && insn_req && slot_free;
	assign insn_ack  = (state == hs_busy);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= hs_idle;
			dec.valid <= 1'b0;
		end else begin
			if (capture)
				dec.valid <= 1'b1;
			else if (dec.ready)
				dec.valid <= 1'b0; // Slot frees on transfer
			if (capture)
				state <= hs_busy;
			else if (state == hs_busy && !insn_req)
				state <= hs_idle; // Ack drops next cycle
		end
	end

	// Output slot payload
	always_ff @(posedge clk) begin
		if (capture) begin
			dec.cls     <= cls_d;
			dec.alu     <= alu_d;
			dec.rs1     <= insn[19:15];
			dec.rs2     <= insn[24:20];
			dec.rd      <= rd_d;
			dec.use_imm <= use_imm_d;
			dec.imm     <= imm_d;
			dec.pc      <= pc;
			dec.target  <= pc + imm_d;
		end
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(insn_ack) |-> insn_req);

endmodule

// ==== hw/rv32_execute.sv ====
// RV32I execution unit
// Register file, ALU, branch resolution and four-phase retirement
`timescale 1ns/1ps

module rv32_execute import rv32_isa_pkg::*, rv32_pipe_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	decoded_op_if.snk op,
	output logic     retire_req,
	input  logic     retire_ack,
	output xlen_t    retire_pc,
	output reg_idx_t retire_rd,
	output xlen_t    retire_wdata,
	output xlen_t    retire_pc_next,
	output logic     retire_trap
);

	localparam xlen_t SIGN_BIT = 32'h8000_0000;

	xlen_t     regs [NUM_REGS];
	hs_state_e state;
	xlen_t     rs1_val, rs2_val, b_val;
	shamt_t    shamt;
	logic      lt_s, lt_u, eq;
	logic      take;
	xlen_t     alu_res, link, jalr_sum;
	xlen_t     wdata_d, pc_next_d;
	logic      wr_d, trap_d;
	logic      accept;

	assign rs1_val = (op.rs1 == '0) ? '0 : regs[op.rs1]; // x0 reads as zero
	assign rs2_val = (op.rs2 == '0) ? '0 : regs[op.rs2];
	assign b_val   = op.use_imm ? op.imm : rs2_val;
	assign shamt   = b_val[4:0];

	assign lt_s = (rs1_val ^ SIGN_BIT) < (b_val ^ SIGN_BIT); // Signed via flipped MSB
	assign lt_u = rs1_val < b_val;
	assign eq   = (rs1_val == b_val);

	always_comb begin
		alu_res = rs1_val + b_val;
		take    = 1'b0;
		case (op.alu)
			alu_sub:  alu_res = rs1_val - b_val;
			alu_sll:  alu_res = rs1_val << shamt;
			alu_slt:  alu_res = xlen_t'(lt_s);
			alu_sltu: alu_res = xlen_t'(lt_u);
			alu_xor:  alu_res = rs1_val ^ b_val;
			alu_srl:  alu_res = rs1_val >> shamt;
			alu_sra:  alu_res = xlen_t'($signed(rs1_val) >>> shamt);
			alu_or:   alu_res = rs1_val | b_val;
			alu_and:  alu_res = rs1_val & b_val;
			alu_beq:  take = eq;
			alu_bne:  take = !eq;
			alu_blt:  take = lt_s;
			alu_bge:  take = !lt_s;
			alu_bltu: take = lt_u;
			alu_bgeu: take = !lt_u;
			default:  alu_res = rs1_val + b_val;
		endcase
	end

	assign link     = op.pc + PC_STEP;
	assign jalr_sum = rs1_val + op.imm;

	always_comb begin
		wdata_d   = alu_res;
		pc_next_d = link;
		wr_d      = (op.rd != '0);
		trap_d    = 1'b0;
		case (op.cls)
			cls_lui:   wdata_d = op.imm;
			cls_auipc: wdata_d = op.target;
			cls_jal: begin
				wdata_d   = link;
				pc_next_d = op.target;
			end
			cls_jalr: begin
				wdata_d   = link;
				pc_next_d = {jalr_sum[31:1], 1'b0};
			end
			cls_branch: begin
				wr_d = 1'b0;
				if (take)
					pc_next_d = op.target;
			end
			cls_alu:   wdata_d = alu_res;
			default: begin // Illegal encoding, pc stays put
				wr_d      = 1'b0;
				trap_d    = 1'b1;
				pc_next_d = op.pc;
			end
		endcase
	end

	assign op.ready   = (state == hs_idle);
	assign accept     = op.valid && op.ready;
	assign retire_req = (state == hs_busy);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= hs_idle;
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			case (state)
				hs_idle: if (accept) state <= hs_busy;
				hs_busy: if (retire_ack) state <= hs_wait_release;
				hs_wait_release: if (!retire_ack) state <= hs_idle;
				default: state <= hs_idle;
			endcase
			if (accept && wr_d)
				regs[op.rd] <= wdata_d;
		end
	end

	// Retire record, held until the handshake completes
	always_ff @(posedge clk) begin
		if (accept) begin
			retire_pc      <= op.pc;
			retire_rd      <= wr_d ? op.rd : '0;
			retire_wdata   <= wr_d ? wdata_d : '0;
			retire_pc_next <= pc_next_d;
			retire_trap    <= trap_d;
		end
	end

	// Ack only answers a pending request
	a_ack_answers_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(retire_ack) |-> retire_req);

endmodule

// ==== hw/rv32_isa_pkg.sv ====
// RV32I architectural definitions
// Word and index widths, major opcodes and function field codes
package rv32_isa_pkg;

	typedef logic [31:0] xlen_t;    // Register or data word
	typedef logic [4:0]  reg_idx_t; // Register index
	typedef logic [31:0] insn_t;    // Raw instruction word
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;
	typedef logic [4:0]  shamt_t;   // Shift amount

	localparam int    NUM_REGS = 32;
	localparam xlen_t PC_STEP  = 32'd4; // No compressed subset

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	// OP and OP-IMM funct3
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SR      = 3'b101; // SRL or SRA by funct7
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// Branch funct3
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_JALR = 3'b000; // Only legal JALR encoding

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000; // SUB and SRA

endpackage

// ==== hw/rv32_pipe_pkg.sv ====
// Core microarchitecture definitions
// Operation classes, ALU functions and four-phase handshake states
package rv32_pipe_pkg;

	// Work for the execution unit
	typedef enum logic [2:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_alu,
		cls_illegal
	} op_class_e;

	// ALU functions, then branch conditions
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and,
		alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
	} alu_op_e;

	typedef enum logic [1:0] {
		hs_idle,         // Waiting for a new request
		hs_busy,         // Request or ack asserted
		hs_wait_release  // Waiting for the far side to drop
	} hs_state_e;

endpackage

// ==== verif/rv32_stimulus.txt ====
# Columns, all hex: pc insn trap rd wdata pc_next, then the assembly as a note
# x1 = 5 and x2 = -3 feed most of the later checks
00000000 00500093 0 01 00000005 00000004 addi x1, x0, 5
00000004 ffd00113 0 02 fffffffd 00000008 addi x2, x0, -3
00000008 002081b3 0 03 00000002 0000000c add x3, x1, x2
0000000c 40208233 0 04 00000008 00000010 sub x4, x1, x2
00000010 401152b3 0 05 ffffffff 00000014 sra x5, x2, x1
00000014 00115333 0 06 07ffffff 00000018 srl x6, x2, x1
00000018 00309393 0 07 00000028 0000001c slli x7, x1, 3
0000001c 00112433 0 08 00000001 00000020 slt x8, x2, x1
00000020 001134b3 0 09 00000000 00000024 sltu x9, x2, x1
00000024 0f014513 0 0a ffffff0d 00000028 xori x10, x2, 0xf0
00000028 0070e5b3 0 0b 0000002d 0000002c or x11, x1, x7
0000002c 0ff57613 0 0c 0000000d 00000030 andi x12, x10, 0xff
00000030 123456b7 0 0d 12345000 00000034 lui x13, 0x12345
00000034 00001717 0 0e 00001034 00000038 auipc x14, 0x1
00000038 00108463 0 00 00000000 00000040 beq x1, x1, +8 taken
0000003c 00109463 0 00 00000000 00000040 bne x1, x1, +8 not taken
00000040 00114463 0 00 00000000 00000048 blt x2, x1, +8 taken
00000044 00115463 0 00 00000000 00000048 bge x2, x1, +8 not taken
00000048 00116463 0 00 00000000 0000004c bltu x2, x1, +8 not taken
0000004c fe117ce3 0 00 00000000 00000044 bgeu x2, x1, -8 taken
00000050 010007ef 0 0f 00000054 00000060 jal x15, +16
00000054 01008867 0 10 00000058 00000014 jalr x16, 16(x1) bit 0 cleared
00000058 000091e7 1 00 00000000 00000058 jalr with funct3 001 traps
0000005c 02208233 1 00 00000000 0000005c funct7 0000001 on x4 traps
00000060 00112463 1 00 00000000 00000060 branch funct3 010 traps
00000064 00018893 0 11 00000002 00000068 addi x17, x3, 0 sees old x3
00000068 00020933 0 12 00000008 0000006c add x18, x4, x0 sees old x4
0000006c 00708013 0 00 00000000 00000070 addi x0, x1, 7 discarded
00000070 001009b3 0 13 00000005 00000074 add x19, x0, x1

// ==== verif/tb_rv32_core.sv ====
// Testbench for the decoupled RV32I core
// Replays a stimulus file over the four-phase ports and checks every retirement
`timescale 1ns/1ps

module tb_rv32_core import rv32_isa_pkg::*;;

	localparam int MAX_LINES       = 64;
	localparam int CYCLES_PER_LINE = 20; // Watchdog budget

	logic     clk;
	logic     rst_n;
	logic     insn_req;
	logic     insn_ack;
	insn_t    insn;
	xlen_t    pc;
	logic     retire_req;
	logic     retire_ack;
	xlen_t    retire_pc;
	reg_idx_t retire_rd;
	xlen_t    retire_wdata;
	xlen_t    retire_pc_next;
	logic     retire_trap;

	xlen_t    stim_pc     [MAX_LINES];
	insn_t    stim_insn   [MAX_LINES];
	logic     exp_trap    [MAX_LINES];
	reg_idx_t exp_rd      [MAX_LINES];
	xlen_t    exp_wdata   [MAX_LINES];
	xlen_t    exp_pc_next [MAX_LINES];
	int       num_lines;
	logic     loaded;
	integer   seed;

	rv32_core_top #(
		.QUEUE_DEPTH (4)
	) u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.insn_req       (insn_req),
		.insn_ack       (insn_ack),
		.insn           (insn),
		.pc             (pc),
		.retire_req     (retire_req),
		.retire_ack     (retire_ack),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_wdata   (retire_wdata),
		.retire_pc_next (retire_pc_next),
		.retire_trap    (retire_trap)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Run aborted");
	endtask

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
			abort_run("A DUT output did not match its expected value");
		end
	endtask

	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_pc, f_insn, f_trap, f_rd, f_wdata, f_next;
		num_lines = 0;
		fd = $fopen("verif/rv32_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open verif/rv32_stimulus.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h",
					f_pc, f_insn, f_trap, f_rd, f_wdata, f_next);
				if (n == 6 && num_lines < MAX_LINES) begin // Comment lines give no match
					stim_pc[num_lines]     = f_pc;
					stim_insn[num_lines]   = f_insn;
					exp_trap[num_lines]    = f_trap[0];
					exp_rd[num_lines]      = f_rd[4:0];
					exp_wdata[num_lines]   = f_wdata;
					exp_pc_next[num_lines] = f_next;
					num_lines++;
				end
			end
			$fclose(fd);
			if (num_lines == 0)
				abort_run("The stimulus file holds no instructions");
		end
	endtask

	// One request per line, each handshake fully released before the next
	task automatic drive_intake();
		@(posedge clk);
		for (int i = 0; i < num_lines; i++) begin
			insn_req <= 1'b1;
			insn     <= stim_insn[i];
			pc       <= stim_pc[i];
			do @(posedge clk); while (!insn_ack);
			insn_req <= 1'b0;
			do @(posedge clk); while (insn_ack);
		end
	endtask

	task automatic collect_retire();
		int delay;
		for (int i = 0; i < num_lines; i++) begin
			do @(posedge clk); while (!retire_req);
			check_value($sformatf("retire_pc[%0d]", i), retire_pc, stim_pc[i]);
			check_value($sformatf("retire_trap[%0d]", i), 32'(retire_trap), 32'(exp_trap[i]));
			check_value($sformatf("retire_rd[%0d]", i), 32'(retire_rd), 32'(exp_rd[i]));
			check_value($sformatf("retire_wdata[%0d]", i), retire_wdata, exp_wdata[i]);
			check_value($sformatf("retire_pc_next[%0d]", i), retire_pc_next, exp_pc_next[i]);
			delay = int'($unsigned($random(seed)) % 4); // 0 to 3 cycles
			repeat (delay) @(posedge clk);
			retire_ack <= 1'b1;
			do @(posedge clk); while (retire_req);
			retire_ack <= 1'b0;
		end
	endtask

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		insn_req   = 1'b0;
		insn       = '0;
		pc         = '0;
		retire_ack = 1'b0;
		loaded     = 1'b0;
		seed       = 32'h96249e1e;
		load_stimulus();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		fork
			drive_intake();
			collect_retire();
		join
		// No extra retirement may follow the last line
		repeat (10) begin
			@(posedge clk);
			check_value("retire_req", 32'(retire_req), 32'd0);
		end
		$display("Verification passed");
		$finish;
	end

	initial begin : watchdog
		wait (loaded);
		repeat (num_lines * CYCLES_PER_LINE) @(posedge clk);
		abort_run($sformatf("Timeout: the program did not retire within %0d cycles",
			num_lines * CYCLES_PER_LINE));
	end

endmodule
